/* hdl/blit_defs.svh */
// Blitter width definitions

`ifndef BLIT_DEFS_SVH
`define BLIT_DEFS_SVH

// Byte addresses, offsets, the base and the line pitch all share this width.
// The adder core and the address register are built to it.
`define BLIT_ADDR_W 32

// Width and height of a rectangle, the pixel and line counters, and the
// pixel step in bytes.
// A rectangle is at most 65535 by 65535 pixels.
`define BLIT_CNT_W 16

`endif

/* hdl/blit_pkg.sv */
// Blitter shared types

`include "blit_defs.svh"

package blit_pkg;

	// Byte address or byte offset in the 32-bit space
	typedef logic [`BLIT_ADDR_W-1:0] addr_t;

	// Pixel count along a line or line count down a rectangle
	typedef logic [`BLIT_CNT_W-1:0] count_t;

	// Unsigned distance in bytes between neighbouring pixels of a line
	typedef logic [`BLIT_CNT_W-1:0] step_t;

endpackage

/* hdl/fa332.sv */
// Three-operand adder

`timescale 1ns/1ps

`include "blit_defs.svh"

module fa332 (
	input  logic [`BLIT_ADDR_W-1:0] a,
	input  logic [`BLIT_ADDR_W-1:0] b,
	input  logic [`BLIT_ADDR_W-1:0] c,
	input  logic                    ci0,
	input  logic                    ci1,
	output logic [`BLIT_ADDR_W-1:0] s,
	output logic                    co0,
	output logic                    co1
);

	logic [`BLIT_ADDR_W-1:0] st; // Partial sum of a and b

	// The two carry chains stay separate, so each stage reports its own carry
	assign {co0, st} = a + b + {{(`BLIT_ADDR_W-1){1'b0}}, ci0};
	assign {co1, s} = c + st + {{(`BLIT_ADDR_W-1){1'b0}}, ci1};

endmodule

/* hdl/blit_loop_counter.sv */
// Blitter pixel and line counter

`timescale 1ns/1ps

`include "blit_defs.svh"

module blit_loop_counter (
	input  logic              clk,
	input  logic              reset,
	input  logic              start,
	input  logic              step,
	input  blit_pkg::count_t  width,
	input  blit_pkg::count_t  height,
	output logic              busy,
	output logic              load,
	output logic              advance,
	output logic              line_end,
	output logic              done
);

	logic [`BLIT_CNT_W-1:0] x_cnt; // Pixel index within the current line
	logic [`BLIT_CNT_W-1:0] y_cnt; // Line index within the rectangle
	blit_pkg::count_t w_last; // Index of the last pixel of a line
	blit_pkg::count_t h_last; // Index of the last line
	logic last; // Advance that issues the final pixel

	assign load = start && !busy;
	assign advance = step && busy;
	assign line_end = advance && (x_cnt == w_last);
	assign last = line_end && (y_cnt == h_last);

	// A zero size walks as a size of one
	always_ff @(posedge clk) begin
		if (load) begin
			w_last <= (width == '0) ? '0 : width - 1'b1;
			h_last <= (height == '0) ? '0 : height - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			x_cnt <= '0;
			y_cnt <= '0;
		end else begin
			done <= last; // Lines up with the last addr_valid
			if (load) begin
				busy <= 1'b1;
				x_cnt <= '0;
				y_cnt <= '0;
			end else if (advance) begin
				if (last) begin
					busy <= 1'b0;
				end
				if (line_end) begin
					x_cnt <= '0;
					y_cnt <= y_cnt + 1'b1;
				end else begin
					x_cnt <= x_cnt + 1'b1;
				end
			end
		end
	end

	// A walk only finishes on an accepted step
	done_needs_advance: assert property (
		@(posedge clk) disable iff (reset)
		done |-> $past(advance)
	);

endmodule

/* hdl/blit_offset_accum.sv */
// Blitter offset accumulator

`timescale 1ns/1ps

`include "blit_defs.svh"

module blit_offset_accum (
	input  logic             clk,
	input  logic             reset,
	input  logic             load,
	input  logic             advance,
	input  logic             line_end,
	input  blit_pkg::step_t  x_step,
	input  blit_pkg::addr_t  pitch,
	output blit_pkg::addr_t  x_off,
	output blit_pkg::addr_t  line_off
);

	blit_pkg::addr_t step_r; // Pixel step widened to an address
	blit_pkg::addr_t pitch_r;

	always_ff @(posedge clk) begin
		if (load) begin
			step_r <= {{(`BLIT_ADDR_W-$bits(blit_pkg::step_t)){1'b0}}, x_step};
			pitch_r <= pitch;
		end
	end

	// Offsets always describe the pixel that the next step will issue
	always_ff @(posedge clk) begin
		if (reset) begin
			x_off <= '0;
			line_off <= '0;
		end else if (load) begin
			x_off <= '0;
			line_off <= '0;
		end else if (advance) begin
			if (line_end) begin
				x_off <= '0; // Back to the start of the line
				line_off <= line_off + pitch_r;
			end else begin
				x_off <= x_off + step_r;
			end
		end
	end

	// A gap in step must leave the walk exactly where it was
	offsets_hold: assert property (
		@(posedge clk) disable iff (reset)
		($changed(x_off) || $changed(line_off)) |-> $past(load || advance)
	);

endmodule

/* hdl/blit_addr_stage.sv */
// Blitter address stage

`timescale 1ns/1ps

`include "blit_defs.svh"

module blit_addr_stage (
	input  logic             clk,
	input  logic             reset,
	input  logic             load,
	input  logic             advance,
	input  blit_pkg::addr_t  base,
	input  blit_pkg::addr_t  x_off,
	input  blit_pkg::addr_t  line_off,
	input  logic             x_dir,
	input  logic             y_dir,
	output blit_pkg::addr_t  addr,
	output logic             addr_valid,
	output logic             wrap
);

	blit_pkg::addr_t base_r;
	logic x_dir_r; // High walks pixels towards lower addresses
	logic y_dir_r; // High walks lines towards lower addresses
	blit_pkg::addr_t pix_term;
	blit_pkg::addr_t line_term;
	logic [`BLIT_ADDR_W-1:0] sum;
	logic co0;
	logic co1;
	logic wrap_next;

	always_ff @(posedge clk) begin
		if (load) begin
			base_r <= base;
			x_dir_r <= x_dir;
			y_dir_r <= y_dir;
		end
	end

	// Subtraction is the inverted offset plus a carry of one
	assign pix_term = x_dir_r ? ~x_off : x_off;
	assign line_term = y_dir_r ? ~line_off : line_off;

	fa332 adder_i (
		.a   (base_r),
		.b   (pix_term),
		.c   (line_term),
		.ci0 (x_dir_r),
		.ci1 (y_dir_r),
		.s   (sum),
		.co0 (co0),
		.co1 (co1)
	);

	// A subtracting stage carries out unless it borrowed
	assign wrap_next = (co0 != x_dir_r) || (co1 != y_dir_r);

	always_ff @(posedge clk) begin
		if (advance) begin
			addr <= sum;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			addr_valid <= 1'b0;
			wrap <= 1'b0;
		end else begin
			addr_valid <= advance;
			if (advance) begin
				wrap <= wrap_next;
			end
		end
	end

	// Configuration must have been loaded before any address goes out
	addr_known: assert property (
		@(posedge clk) disable iff (reset)
		addr_valid |-> !$isunknown(addr)
	);

endmodule

/* hdl/blit_addr_gen.sv */
// Blitter address generator

`timescale 1ns/1ps

`include "blit_defs.svh"

module blit_addr_gen (
	input  logic              clk,
	input  logic              reset,
	input  logic              start,
	input  logic              step,
	input  logic              x_dir,
	input  logic              y_dir,
	input  blit_pkg::addr_t   base,
	input  blit_pkg::addr_t   pitch,
	input  blit_pkg::step_t   x_step,
	input  blit_pkg::count_t  width,
	input  blit_pkg::count_t  height,
	output logic              busy,
	output logic              addr_valid,
	output logic              wrap,
	output logic              done,
	output blit_pkg::addr_t   addr
);

	logic load;
	logic advance;
	logic line_end;
	blit_pkg::addr_t x_off; // Offset of the next pixel within its line
	blit_pkg::addr_t line_off; // Offset of the line holding the next pixel

	blit_loop_counter counter_i (
		.clk      (clk),
		.reset    (reset),
		.start    (start),
		.step     (step),
		.width    (width),
		.height   (height),
		.busy     (busy),
		.load     (load),
		.advance  (advance),
		.line_end (line_end),
		.done     (done)
	);

	blit_offset_accum accum_i (
		.clk      (clk),
		.reset    (reset),
		.load     (load),
		.advance  (advance),
		.line_end (line_end),
		.x_step   (x_step),
		.pitch    (pitch),
		.x_off    (x_off),
		.line_off (line_off)
	);

	// Base and directions are taken at the same load as the sizes
	blit_addr_stage stage_i (
		.clk        (clk),
		.reset      (reset),
		.load       (load),
		.advance    (advance),
		.base       (base),
		.x_off      (x_off),
		.line_off   (line_off),
		.x_dir      (x_dir),
		.y_dir      (y_dir),
		.addr       (addr),
		.addr_valid (addr_valid),
		.wrap       (wrap)
	);

endmodule

/* test/blit_addr_gen_tb.sv */
// Blitter address generator testbench

`timescale 1ns/1ps

`include "blit_defs.svh"

module blit_addr_gen_tb;

	localparam int WALK_LIMIT = 400; // Cycles allowed to issue one rectangle
	localparam int DONE_LIMIT = 20;

	logic clk;
	logic reset;
	logic start;
	logic step;
	logic x_dir;
	logic y_dir;
	blit_pkg::addr_t base;
	blit_pkg::addr_t pitch;
	blit_pkg::step_t x_step;
	blit_pkg::count_t width;
	blit_pkg::count_t height;
	logic busy;
	logic addr_valid;
	logic wrap;
	logic done;
	blit_pkg::addr_t addr;

	// Reference model state, updated on the falling edge together with the inputs
	logic started;
	logic model_busy;
	logic exp_valid; // An accepted step is being driven this cycle
	logic exp_last;
	logic exp_wrap;
	blit_pkg::addr_t exp_addr;
	blit_pkg::addr_t m_base;
	blit_pkg::addr_t m_step;
	blit_pkg::addr_t m_pitch;
	logic m_xdir;
	logic m_ydir;

	int errors = 0;
	int timeouts = 0;
	int rects = 0;
	int unsigned seen_cnt = 0;

	blit_addr_gen dut_i (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.step       (step),
		.x_dir      (x_dir),
		.y_dir      (y_dir),
		.base       (base),
		.pitch      (pitch),
		.x_step     (x_step),
		.width      (width),
		.height     (height),
		.busy       (busy),
		.addr_valid (addr_valid),
		.wrap       (wrap),
		.done       (done),
		.addr       (addr)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		if (!reset && addr_valid) begin
			seen_cnt <= seen_cnt + 1;
		end
	end

	task automatic report_error(input string msg);
		errors++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	// Real subtraction in 33 bits, so bit 32 is the borrow when going down
	function automatic logic [`BLIT_ADDR_W:0] model_pixel(input int unsigned col,
			input int unsigned row);
		blit_pkg::addr_t xo;
		blit_pkg::addr_t lo;
		logic [`BLIT_ADDR_W:0] part;
		logic [`BLIT_ADDR_W:0] full;
		xo = col * m_step;
		lo = row * m_pitch;
		if (m_xdir) begin
			part = {1'b0, m_base} - {1'b0, xo};
		end else begin
			part = {1'b0, m_base} + {1'b0, xo};
		end
		if (m_ydir) begin
			full = {1'b0, part[`BLIT_ADDR_W-1:0]} - {1'b0, lo};
		end else begin
			full = {1'b0, part[`BLIT_ADDR_W-1:0]} + {1'b0, lo};
		end
		return {part[`BLIT_ADDR_W] || full[`BLIT_ADDR_W], full[`BLIT_ADDR_W-1:0]};
	endfunction

	// Configuration is only taken with start, so anything else must be harmless
	task automatic scramble_config;
		base = $urandom;
		pitch = $urandom;
		x_step = blit_pkg::step_t'($urandom);
		width = blit_pkg::count_t'($urandom);
		height = blit_pkg::count_t'($urandom);
		x_dir = $urandom_range(0, 1);
		y_dir = $urandom_range(0, 1);
	endtask

	task automatic run_rect(input blit_pkg::addr_t b, input blit_pkg::step_t s,
			input blit_pkg::addr_t p, input blit_pkg::count_t w, input blit_pkg::count_t h,
			input logic xd, input logic yd);
		int unsigned n_w;
		int unsigned n_h;
		int unsigned total;
		int unsigned issued;
		int unsigned col;
		int unsigned row;
		int unsigned seen_before;
		int cycles;
		logic [`BLIT_ADDR_W:0] expected;
		if (timeouts != 0) begin
			return;
		end
		n_w = (w == '0) ? 1 : w;
		n_h = (h == '0) ? 1 : h;
		total = n_w * n_h;
		issued = 0;
		col = 0;
		row = 0;
		seen_before = seen_cnt;
		base = b;
		x_step = s;
		pitch = p;
		width = w;
		height = h;
		x_dir = xd;
		y_dir = yd;
		start = 1'b1;
		step = 1'b0;
		m_base = b;
		m_step = blit_pkg::addr_t'(s);
		m_pitch = p;
		m_xdir = xd;
		m_ydir = yd;
		started = 1'b1;
		model_busy = 1'b1;
		exp_valid = 1'b0;
		exp_last = 1'b0;
		rects++;
		cycles = 0;
		@(negedge clk);
		while (issued < total && cycles < WALK_LIMIT) begin
			scramble_config();
			start = 1'b0;
			step = 1'b0;
			exp_valid = 1'b0;
			if ($urandom_range(0, 2) != 0) begin
				expected = model_pixel(col, row);
				exp_addr = expected[`BLIT_ADDR_W-1:0];
				exp_wrap = expected[`BLIT_ADDR_W];
				exp_valid = 1'b1;
				issued++;
				exp_last = (issued == total);
				if (exp_last) begin
					model_busy = 1'b0;
				end
				step = 1'b1;
				if (col == n_w - 1) begin // Row order, next line starts at column zero
					col = 0;
					row++;
				end else begin
					col++;
				end
			end else if ($urandom_range(0, 3) == 0) begin
				start = 1'b1; // Ignored mid-walk
			end
			cycles++;
			@(negedge clk);
		end
		step = 1'b0;
		start = 1'b0;
		exp_valid = 1'b0;
		if (issued < total) begin
			$display("Timeout: the %0dx%0d walk did not get all its steps issued", n_w, n_h);
			timeouts++;
			return;
		end
		cycles = 0;
		while (!done && cycles < DONE_LIMIT) begin
			cycles++;
			@(negedge clk);
		end
		if (!done) begin
			$display("Timeout: done never pulsed after the %0dx%0d walk", n_w, n_h);
			timeouts++;
			return;
		end
		repeat (3) begin
			step = $urandom_range(0, 1); // Steps while idle
			@(negedge clk);
		end
		step = 1'b0;
		@(negedge clk);
		pixel_count: assert (seen_cnt - seen_before == total)
		else report_error($sformatf("%0d addresses for a %0dx%0d rectangle",
			seen_cnt - seen_before, n_w, n_h));
	endtask

	task automatic random_rect(input logic xd, input logic yd);
		run_rect($urandom, blit_pkg::step_t'($urandom), $urandom,
			blit_pkg::count_t'($urandom_range(1, 6)),
			blit_pkg::count_t'($urandom_range(1, 6)), xd, yd);
	endtask

	initial begin
		void'($urandom(32'h657e20d9));
		reset = 1'b1;
		start = 1'b0;
		step = 1'b0;
		base = '0;
		pitch = '0;
		x_step = '0;
		width = '0;
		height = '0;
		x_dir = 1'b0;
		y_dir = 1'b0;
		started = 1'b0;
		model_busy = 1'b0;
		exp_valid = 1'b0;
		exp_last = 1'b0;
		exp_wrap = 1'b0;
		exp_addr = '0;
		m_base = '0;
		m_step = '0;
		m_pitch = '0;
		m_xdir = 1'b0;
		m_ydir = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		repeat (5) begin
			step = $urandom_range(0, 1);
			@(negedge clk);
		end
		step = 1'b0;
		for (int d = 0; d < 4; d++) begin
			repeat (3) random_rect(d[0], d[1]);
		end
		run_rect($urandom, blit_pkg::step_t'($urandom), $urandom, 16'd0, 16'd3, 1'b0, 1'b1);
		run_rect($urandom, blit_pkg::step_t'($urandom), $urandom, 16'd4, 16'd0, 1'b1, 1'b0);
		run_rect($urandom, blit_pkg::step_t'($urandom), $urandom, 16'd0, 16'd0, 1'b1, 1'b1);
		// Bases at the ends of the address space, both crossing and staying inside
		run_rect(32'hffff_fff0 + $urandom_range(0, 15), 16'd4, 32'h40, 16'd4, 16'd3, 1'b0, 1'b0);
		run_rect(32'hffff_ff80, 16'd8, 32'h20, 16'd3, 16'd3, 1'b1, 1'b1);
		run_rect(32'h0000_0008, 16'd4, 32'h20, 16'd4, 16'd3, 1'b1, 1'b1);
		run_rect(32'h0000_0004, 16'd2, 32'h10, 16'd5, 16'd2, 1'b1, 1'b0);
		run_rect(32'h0000_0000, 16'd4, 32'h100, 16'd3, 16'd4, 1'b0, 1'b0);
		run_rect(32'hffff_fffc, 16'd1, 32'h8, 16'd6, 16'd2, 1'b0, 1'b1);
		repeat (5) random_rect($urandom_range(0, 1), $urandom_range(0, 1));
		repeat (4) @(negedge clk);
		$display("Summary: %0d rectangles, %0d addresses, %0d errors, %0d timeouts",
			rects, seen_cnt, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	quiet_before_start: assert property (
		@(posedge clk) disable iff (reset)
		!started |-> (!busy && !addr_valid && !done && !wrap)
	) else report_error("output active before the first start");

	valid_follows_step: assert property (
		@(posedge clk) disable iff (reset)
		addr_valid == $past(exp_valid)
	) else report_error("addr_valid does not follow an accepted step by one cycle");

	addr_matches_model: assert property (
		@(posedge clk) disable iff (reset)
		addr_valid |-> (addr == $past(exp_addr) && wrap == $past(exp_wrap))
	) else report_error("address or wrap does not match the model");

	done_only_with_last: assert property (
		@(posedge clk) disable iff (reset)
		done |-> (addr_valid && $past(exp_last))
	) else report_error("done without the last address");

	last_brings_done: assert property (
		@(posedge clk) disable iff (reset)
		(addr_valid && $past(exp_last)) |-> (done && !busy)
	) else report_error("last address without done, or busy still high");

	busy_tracks_model: assert property (
		@(posedge clk) disable iff (reset)
		busy == $past(model_busy)
	) else report_error("busy differs from the model");

endmodule

/* vlog.f */
+incdir+hdl
hdl/blit_pkg.sv
hdl/fa332.sv
hdl/blit_loop_counter.sv
hdl/blit_offset_accum.sv
hdl/blit_addr_stage.sv
hdl/blit_addr_gen.sv
test/blit_addr_gen_tb.sv

/* Bender.yml */
package:
  name: blit_addr_gen

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/blit_pkg.sv
      - hdl/fa332.sv
      - hdl/blit_loop_counter.sv
      - hdl/blit_offset_accum.sv
      - hdl/blit_addr_stage.sv
      - hdl/blit_addr_gen.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - test/blit_addr_gen_tb.sv
